/* hdl/attn_pkg.sv */
`default_nettype none

package attn_pkg;

    ////////////////////////////////////////
    // array and tile sizes
    ////////////////////////////////////////
    localparam int D_W        = 8;          // element width
    localparam int TILE       = 4;          // tile edge
    localparam int N_QO_TILES = 2;          // q/o row tiles
    localparam int N_KV_TILES = 2;          // k/v row tiles
    localparam int N_COL      = 2;          // column chunks per row tile

    localparam int MAX_TILES = (N_QO_TILES > N_KV_TILES) ? N_QO_TILES : N_KV_TILES;
    localparam int LINE_W    = (MAX_TILES > 1) ? $clog2(MAX_TILES) : 1;
    localparam int COL_W     = (N_COL > 1) ? $clog2(N_COL) : 1;

    // 1/sqrt(d_k) with 5 fraction bits, d_k = 128
    localparam logic [D_W-1:0] SCALE_DK = 8'd3;

    // row major, [row][col][bit]
    typedef logic [TILE-1:0][TILE-1:0][D_W-1:0] tile_t;

    typedef enum logic [1:0] {
        MAT_Q = 2'd0,
        MAT_K = 2'd1,
        MAT_V = 2'd2,
        MAT_O = 2'd3
    } mat_sel_e;

    // operand being formed for the SA
    typedef enum logic [2:0] {
        STEP_IDLE   = 3'd0,
        STEP_LOAD_K = 3'd1,
        STEP_TRANS  = 3'd2,
        STEP_LOAD_Q = 3'd3,     // also covers the q*k^t pass
        STEP_SCALE  = 3'd4,
        STEP_PV     = 3'd5,
        STEP_O_UPD  = 3'd6      // o read, add and write back
    } seq_step_e;

endpackage

`default_nettype wire

/* hdl/tile_mem_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface tile_mem_if;
    import attn_pkg::*;

    logic              req_rd;      // one-cycle read request
    logic              req_wr;      // one-cycle write request
    mat_sel_e          mat_sel;
    logic [LINE_W-1:0] line;
    logic [COL_W-1:0]  col;
    seq_step_e         step;        // step the request belongs to
    logic              done;        // one-cycle completion
    tile_t             rd_tile;     // tile captured on read

    modport seq (
        output req_rd, req_wr, mat_sel, line, col, step,
        input  done, rd_tile
    );

    modport mem (
        input  req_rd, req_wr, mat_sel, line, col, step,
        output done, rd_tile
    );

endinterface

`default_nettype wire

/* hdl/attn_tile_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module attn_tile_seq (
    input  wire logic                I_CLK,
    input  wire logic                I_RST_N,
    input  wire logic                i_attn_start,
    input  wire logic                i_sa_vld,
    output logic                     o_sa_start,
    output attn_pkg::seq_step_e      o_step,
    output logic                     o_data_vld,
    tile_mem_if.seq                  mem
);
    import attn_pkg::*;

    typedef enum logic [4:0] {
        S_IDLE,
        S_RD_K,    S_WAIT_K,  S_TRANS,
        S_RD_Q,    S_WAIT_Q,  S_GO_QK,   S_SA_QK,
        S_SC_LOAD, S_GO_SC,   S_SA_SC,
        S_RD_V,    S_WAIT_V,  S_GO_PV,   S_SA_PV,
        S_RD_O,    S_WAIT_O,  S_WR,      S_WAIT_WR
    } state_e;

    state_e            state;
    logic [LINE_W-1:0] kv_cnt;
    logic [LINE_W-1:0] qo_cnt;
    logic [COL_W-1:0]  col_cnt;
    logic              last_col;
    logic              last_qo;
    logic              last_kv;
    logic              req_busy;

    assign last_col = (col_cnt == COL_W'(N_COL - 1));
    assign last_qo  = (qo_cnt == LINE_W'(N_QO_TILES - 1));
    assign last_kv  = (kv_cnt == LINE_W'(N_KV_TILES - 1));

    ////////////////////////////////////////
    // loop walk: kv outer, qo inner, chunks
    ////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state   <= S_IDLE;
            kv_cnt  <= '0;
            qo_cnt  <= '0;
            col_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_attn_start) begin
                        state   <= S_RD_K;
                        kv_cnt  <= '0;
                        qo_cnt  <= '0;
                        col_cnt <= '0;
                    end
                end
                S_RD_K:    state <= S_WAIT_K;
                S_WAIT_K:  if (mem.done) state <= S_TRANS;
                S_TRANS:   state <= S_RD_Q;
                S_RD_Q:    state <= S_WAIT_Q;
                S_WAIT_Q:  if (mem.done) state <= S_GO_QK;
                S_GO_QK:   state <= S_SA_QK;        // operands settle
                S_SA_QK: begin
                    if (i_sa_vld) begin
                        if (last_col) begin
                            col_cnt <= '0;
                            state   <= S_SC_LOAD;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                            state   <= S_RD_K;
                        end
                    end
                end
                S_SC_LOAD: state <= S_GO_SC;        // s and diag registered
                S_GO_SC:   state <= S_SA_SC;
                S_SA_SC:   if (i_sa_vld) state <= S_RD_V;
                S_RD_V:    state <= S_WAIT_V;
                S_WAIT_V:  if (mem.done) state <= S_GO_PV;
                S_GO_PV:   state <= S_SA_PV;
                S_SA_PV:   if (i_sa_vld) state <= S_RD_O;
                S_RD_O:    state <= S_WAIT_O;
                S_WAIT_O:  if (mem.done) state <= S_WR;
                S_WR:      state <= S_WAIT_WR;
                S_WAIT_WR: begin
                    if (mem.done) begin
                        if (!last_col) begin
                            col_cnt <= col_cnt + 1'b1;
                            state   <= S_RD_V;  // next chunk of p*v
                        end else begin
                            col_cnt <= '0;
                            state   <= S_RD_K;
                            if (!last_qo) begin
                                qo_cnt <= qo_cnt + 1'b1;
                            end else begin
                                qo_cnt <= '0;
                                if (!last_kv) begin
                                    kv_cnt <= kv_cnt + 1'b1;
                                end else begin
                                    kv_cnt <= '0;   // run finished
                                    state  <= S_IDLE;
                                end
                            end
                        end
                    end
                end
                default:   state <= S_IDLE;
            endcase
        end
    end

    // start goes out one cycle after the settle state
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            o_sa_start <= 1'b0;
        end else begin
            o_sa_start <= (state == S_GO_QK) || (state == S_GO_SC) || (state == S_GO_PV);
        end
    end

    assign o_data_vld = (state == S_WAIT_WR) && mem.done && last_col && last_qo && last_kv;

    always_comb begin
        case (state)
            S_RD_K, S_WAIT_K:                     o_step = STEP_LOAD_K;
            S_TRANS:                              o_step = STEP_TRANS;
            S_RD_Q, S_WAIT_Q, S_GO_QK, S_SA_QK:   o_step = STEP_LOAD_Q;
            S_SC_LOAD, S_GO_SC, S_SA_SC:          o_step = STEP_SCALE;
            S_RD_V, S_WAIT_V, S_GO_PV, S_SA_PV:   o_step = STEP_PV;
            S_RD_O, S_WAIT_O, S_WR, S_WAIT_WR:    o_step = STEP_O_UPD;
            default:                              o_step = STEP_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // memory requests
    ////////////////////////////////////////
    assign mem.req_rd = (state == S_RD_K) || (state == S_RD_Q) ||
                        (state == S_RD_V) || (state == S_RD_O);
    assign mem.req_wr = (state == S_WR);
    assign mem.col    = col_cnt;
    assign mem.step   = o_step;

    always_comb begin
        mem.mat_sel = MAT_O;
        mem.line    = qo_cnt;           // q and o follow the qo tile
        case (state)
            S_RD_K: begin
                mem.mat_sel = MAT_K;
                mem.line    = kv_cnt;
            end
            S_RD_Q: mem.mat_sel = MAT_Q;
            S_RD_V: begin
                mem.mat_sel = MAT_V;
                mem.line    = kv_cnt;
            end
            default: ;
        endcase
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            req_busy <= 1'b0;
        end else if (mem.req_rd || mem.req_wr) begin
            req_busy <= 1'b1;
        end else if (mem.done) begin
            req_busy <= 1'b0;
        end
    end

    // the memory side serves one request at a time
    a_single_req: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        (mem.req_rd || mem.req_wr) |-> !req_busy);

endmodule

`default_nettype wire

/* hdl/tile_mem_access.sv */
`timescale 1ns/100ps
`default_nettype none

module tile_mem_access (
    input  wire logic                   I_CLK,
    input  wire logic                   I_RST_N,
    tile_mem_if.mem                     mem,
    input  wire attn_pkg::tile_t        i_wr_tile,
    input  wire logic                   i_bram_rd_vld,
    input  wire attn_pkg::tile_t        i_bram_rd_mat,
    input  wire logic                   i_bram_wr_done,
    output logic                        o_rd_ena,
    output logic                        o_wr_ena,
    output attn_pkg::mat_sel_e          o_bram_sel_mat,
    output logic [attn_pkg::LINE_W-1:0] o_bram_sel_line,
    output logic [attn_pkg::COL_W-1:0]  o_bram_sel_col
);
    import attn_pkg::*;

    mat_sel_e step_mat;

    ////////////////////////////////////////
    // request pulse to held levels
    ////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            o_rd_ena        <= 1'b0;
            o_wr_ena        <= 1'b0;
            o_bram_sel_mat  <= MAT_Q;
            o_bram_sel_line <= '0;
            o_bram_sel_col  <= '0;
            mem.done        <= 1'b0;
        end else begin
            mem.done <= 1'b0;
            if (mem.req_rd || mem.req_wr) begin
                o_rd_ena        <= mem.req_rd;
                o_wr_ena        <= mem.req_wr;
                o_bram_sel_mat  <= mem.mat_sel;     // selects hold until done
                o_bram_sel_line <= mem.line;
                o_bram_sel_col  <= mem.col;
            end else if (o_rd_ena && i_bram_rd_vld) begin
                o_rd_ena <= 1'b0;
                mem.done <= 1'b1;
            end else if (o_wr_ena && i_bram_wr_done) begin
                o_wr_ena <= 1'b0;
                mem.done <= 1'b1;
            end
        end
    end

    // tile is ready in the done cycle
    always_ff @(posedge I_CLK) begin
        if (o_rd_ena && i_bram_rd_vld) begin
            mem.rd_tile <= i_bram_rd_mat;
        end
    end

    always_comb begin
        case (mem.step)
            STEP_LOAD_K: step_mat = MAT_K;
            STEP_LOAD_Q: step_mat = MAT_Q;
            STEP_PV:     step_mat = MAT_V;
            default:     step_mat = MAT_O;
        endcase
    end

    a_rd_wr_excl: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        !(o_rd_ena && o_wr_ena));

    // sequencer step and requested matrix agree
    a_req_matches_step: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        (mem.req_rd || mem.req_wr) |-> (mem.mat_sel == step_mat));

    // write data from the o accumulator holds for the whole write
    a_wr_data_stable: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        o_wr_ena |-> $stable(i_wr_tile));

endmodule

`default_nettype wire

/* hdl/sa_operand_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module sa_operand_regs (
    input  wire logic                I_CLK,
    input  wire logic                I_RST_N,
    input  wire attn_pkg::seq_step_e i_step,
    input  wire attn_pkg::tile_t     i_rd_tile,
    input  wire logic                i_rd_done,
    input  wire logic                i_sa_vld,
    input  wire attn_pkg::tile_t     i_sa_result,
    output attn_pkg::tile_t          o_mat_1,
    output attn_pkg::tile_t          o_mat_2,
    output attn_pkg::tile_t          o_data_load,
    output attn_pkg::tile_t          o_pv_result
);
    import attn_pkg::*;

    seq_step_e step_q;
    logic      scale_entry;
    tile_t     k_trans;
    tile_t     scale_diag;

    ////////////////////////////////////////
    // transpose of k and scale diagonal
    ////////////////////////////////////////
    always_comb begin
        for (int r = 0; r < TILE; r++) begin
            for (int c = 0; c < TILE; c++) begin
                k_trans[c][r] = o_mat_1[r][c];  // k sits in mat_1 after its read
            end
        end
    end

    always_comb begin
        for (int r = 0; r < TILE; r++) begin
            for (int c = 0; c < TILE; c++) begin
                scale_diag[r][c] = (r == c) ? SCALE_DK : '0;
            end
        end
    end

    assign scale_entry = (i_step == STEP_SCALE) && (step_q != STEP_SCALE);

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            step_q      <= STEP_IDLE;
            o_mat_1     <= '0;
            o_mat_2     <= '0;
            o_data_load <= '0;
            o_pv_result <= '0;
        end else begin
            step_q <= i_step;
            case (i_step)
                STEP_LOAD_K: begin
                    if (i_rd_done) o_mat_1 <= i_rd_tile;
                end
                STEP_TRANS: o_mat_2 <= k_trans;
                STEP_LOAD_Q: begin
                    if (i_rd_done) o_mat_1 <= i_rd_tile;
                    if (i_sa_vld) o_data_load <= i_sa_result;   // partial s fed back
                end
                STEP_SCALE: begin
                    if (scale_entry) begin
                        o_mat_1     <= o_data_load;             // full s
                        o_mat_2     <= scale_diag;
                        o_data_load <= '0;  // zero preload for the next first chunk
                    end else if (i_sa_vld) begin
                        o_mat_1 <= i_sa_result;                 // p, kept for all chunks
                    end
                end
                STEP_PV: begin
                    if (i_rd_done) o_mat_2 <= i_rd_tile;        // v beside p
                    if (i_sa_vld) o_pv_result <= i_sa_result;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/o_tile_accum.sv */
`timescale 1ns/100ps
`default_nettype none

module o_tile_accum (
    input  wire logic            I_CLK,
    input  wire logic            I_RST_N,
    input  wire attn_pkg::tile_t i_o_tile,
    input  wire logic            i_o_load,
    input  wire attn_pkg::tile_t i_pv_result,
    output attn_pkg::tile_t      o_att_data
);
    import attn_pkg::*;

    tile_t o_sum;

    // element-wise add, wraps at D_W bits
    always_comb begin
        for (int r = 0; r < TILE; r++) begin
            for (int c = 0; c < TILE; c++) begin
                o_sum[r][c] = i_o_tile[r][c] + i_pv_result[r][c];
            end
        end
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            o_att_data <= '0;
        end else if (i_o_load) begin
            o_att_data <= o_sum;                // held as write data
        end
    end

endmodule

`default_nettype wire

/* hdl/attn_top.sv */
`timescale 1ns/100ps
`default_nettype none

module attn_top (
    input  wire logic                   I_CLK,
    input  wire logic                   I_RST_N,
    input  wire logic                   i_attn_start,
    // SA side
    input  wire logic                   i_sa_vld,
    input  wire attn_pkg::tile_t        i_sa_result,
    output logic                        o_sa_start,
    output attn_pkg::tile_t             o_mat_1,
    output attn_pkg::tile_t             o_mat_2,
    output attn_pkg::tile_t             o_data_load,
    output logic                        o_data_vld,
    output attn_pkg::tile_t             o_att_data,
    // tile memory side
    input  wire logic                   i_bram_rd_vld,
    input  wire attn_pkg::tile_t        i_bram_rd_mat,
    input  wire logic                   i_bram_wr_done,
    output logic                        o_rd_ena,
    output logic                        o_wr_ena,
    output attn_pkg::mat_sel_e          o_bram_sel_mat,
    output logic [attn_pkg::LINE_W-1:0] o_bram_sel_line,
    output logic [attn_pkg::COL_W-1:0]  o_bram_sel_col
);
    import attn_pkg::*;

    tile_mem_if mem_bus ();

    seq_step_e step;
    tile_t     pv_result;
    logic      o_load;

    assign o_load = o_rd_ena && i_bram_rd_vld && (o_bram_sel_mat == MAT_O);   // stored o arrives

    attn_tile_seq attn_tile_seq_i (
        .I_CLK        (I_CLK),
        .I_RST_N      (I_RST_N),
        .i_attn_start (i_attn_start),
        .i_sa_vld     (i_sa_vld),
        .o_sa_start   (o_sa_start),
        .o_step       (step),
        .o_data_vld   (o_data_vld),
        .mem          (mem_bus.seq)
    );

    tile_mem_access tile_mem_access_i (
        .I_CLK           (I_CLK),
        .I_RST_N         (I_RST_N),
        .mem             (mem_bus.mem),
        .i_wr_tile       (o_att_data),
        .i_bram_rd_vld   (i_bram_rd_vld),
        .i_bram_rd_mat   (i_bram_rd_mat),
        .i_bram_wr_done  (i_bram_wr_done),
        .o_rd_ena        (o_rd_ena),
        .o_wr_ena        (o_wr_ena),
        .o_bram_sel_mat  (o_bram_sel_mat),
        .o_bram_sel_line (o_bram_sel_line),
        .o_bram_sel_col  (o_bram_sel_col)
    );

    sa_operand_regs sa_operand_regs_i (
        .I_CLK       (I_CLK),
        .I_RST_N     (I_RST_N),
        .i_step      (step),
        .i_rd_tile   (mem_bus.rd_tile),
        .i_rd_done   (mem_bus.done),
        .i_sa_vld    (i_sa_vld),
        .i_sa_result (i_sa_result),
        .o_mat_1     (o_mat_1),
        .o_mat_2     (o_mat_2),
        .o_data_load (o_data_load),
        .o_pv_result (pv_result)
    );

    o_tile_accum o_tile_accum_i (
        .I_CLK       (I_CLK),
        .I_RST_N     (I_RST_N),
        .i_o_tile    (i_bram_rd_mat),
        .i_o_load    (o_load),
        .i_pv_result (pv_result),
        .o_att_data  (o_att_data)
    );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial o_clk = 1'b0;
    always #(PERIOD / 2) o_clk = ~o_clk;

    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1 o_rst_n = 1'b1;              // released just after an edge
    end

endmodule

`default_nettype wire

/* tb/tb_models.sv */
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////
// tile memory with random latency
////////////////////////////////////////
module tile_mem_model #(
    parameter int SEED    = 1,
    parameter int MAX_LAT = 4
) (
    input  wire logic                   I_CLK,
    input  wire logic                   i_rd_ena,
    input  wire logic                   i_wr_ena,
    input  wire [1:0]                   i_sel_mat,
    input  wire [attn_pkg::LINE_W-1:0]  i_sel_line,
    input  wire [attn_pkg::COL_W-1:0]   i_sel_col,
    input  wire attn_pkg::tile_t        i_wr_tile,
    output logic                        o_rd_vld,
    output attn_pkg::tile_t             o_rd_mat,
    output logic                        o_wr_done
);
    import attn_pkg::*;

    tile_t       q_mem [N_QO_TILES][N_COL];
    tile_t       k_mem [N_KV_TILES][N_COL];
    tile_t       v_mem [N_KV_TILES][N_COL];
    tile_t       o_mem [N_QO_TILES][N_COL];
    int          seed;
    int          lat;
    logic [31:0] rnd;

    task automatic fill_tile(output tile_t t);
        for (int r = 0; r < TILE; r++) begin
            for (int c = 0; c < TILE; c++) begin
                rnd = $random(seed);
                t[r][c] = rnd[D_W-1:0];
            end
        end
    endtask

    initial begin
        seed      = SEED;
        o_rd_vld  = 1'b0;
        o_wr_done = 1'b0;
        o_rd_mat  = '0;
        for (int l = 0; l < N_QO_TILES; l++) begin
            for (int c = 0; c < N_COL; c++) begin
                fill_tile(q_mem[l][c]);
                fill_tile(o_mem[l][c]);
            end
        end
        for (int l = 0; l < N_KV_TILES; l++) begin
            for (int c = 0; c < N_COL; c++) begin
                fill_tile(k_mem[l][c]);
                fill_tile(v_mem[l][c]);
            end
        end
    end

    always begin
        @(posedge I_CLK);
        #1;
        if (i_rd_ena || i_wr_ena) begin
            rnd = $random(seed);
            lat = 1 + int'(rnd % MAX_LAT);
            repeat (lat) @(posedge I_CLK);
            #1;
            if (i_rd_ena) begin
                case (i_sel_mat)
                    2'd0:    o_rd_mat = q_mem[i_sel_line][i_sel_col];   // q
                    2'd1:    o_rd_mat = k_mem[i_sel_line][i_sel_col];   // k
                    2'd2:    o_rd_mat = v_mem[i_sel_line][i_sel_col];   // v
                    default: o_rd_mat = o_mem[i_sel_line][i_sel_col];
                endcase
                o_rd_vld = 1'b1;
            end else begin
                o_mem[i_sel_line][i_sel_col] = i_wr_tile;  // only O is written
                o_wr_done = 1'b1;
            end
            @(posedge I_CLK);
            #1;
            o_rd_vld  = 1'b0;
            o_wr_done = 1'b0;
        end
    end

endmodule

////////////////////////////////////////
// systolic array, mat_1*mat_2 + preload
////////////////////////////////////////
module sa_model #(
    parameter int SEED    = 1,
    parameter int MAX_LAT = 4
) (
    input  wire logic            I_CLK,
    input  wire logic            i_sa_start,
    input  wire attn_pkg::tile_t i_mat_1,
    input  wire attn_pkg::tile_t i_mat_2,
    input  wire attn_pkg::tile_t i_data_load,
    output logic                 o_sa_vld,
    output attn_pkg::tile_t      o_sa_result
);
    import attn_pkg::*;

    int             seed;
    int             lat;
    logic [31:0]    rnd;
    tile_t          res;
    logic [D_W-1:0] acc;

    initial begin
        seed        = SEED + 1;
        o_sa_vld    = 1'b0;
        o_sa_result = '0;
    end

    always begin
        @(posedge I_CLK);
        #1;
        if (i_sa_start) begin
            for (int r = 0; r < TILE; r++) begin
                for (int c = 0; c < TILE; c++) begin
                    acc = i_data_load[r][c];
                    for (int k = 0; k < TILE; k++) begin
                        acc = acc + i_mat_1[r][k] * i_mat_2[k][c];  // wraps at D_W
                    end
                    res[r][c] = acc;
                end
            end
            rnd = $random(seed);
            lat = 1 + int'(rnd % MAX_LAT);
            repeat (lat) @(posedge I_CLK);
            #1;
            o_sa_result = res;
            o_sa_vld    = 1'b1;
            @(posedge I_CLK);
            #1;
            o_sa_vld = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tb/attn_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module attn_tb;
    import attn_pkg::*;

    localparam int SEED       = 22782;
    localparam int PERIOD     = 40;
    localparam int RST_CYCLES = 8;
    localparam int MAX_LAT    = 4;
    localparam int N_PAIRS    = N_KV_TILES * N_QO_TILES;
    localparam int N_WRITES   = N_PAIRS * N_COL;
    localparam int SA_PER     = 2 * N_COL + 1;         // qk chunks, scale, pv chunks
    localparam int ACC_PER    = 5 * N_COL;
    localparam int WORST      = N_PAIRS * (ACC_PER + SA_PER) * (MAX_LAT + 4) + RST_CYCLES + 20;
    localparam int TIMEOUT_NS = 4 * WORST * PERIOD;

    localparam logic [D_W-1:0] SCALE_VAL = 8'd3;       // 1/sqrt(128) in 5 fraction bits

    // select codes of the tile memory
    localparam int CODE_Q = 0;
    localparam int CODE_K = 1;
    localparam int CODE_V = 2;
    localparam int CODE_O = 3;

    logic I_CLK;
    logic I_RST_N;
    logic i_attn_start;
    logic i_sa_vld;
    logic i_bram_rd_vld;
    logic i_bram_wr_done;
    logic o_sa_start;
    logic o_data_vld;
    logic o_rd_ena;
    logic o_wr_ena;
    tile_t i_sa_result;
    tile_t i_bram_rd_mat;
    tile_t o_mat_1;
    tile_t o_mat_2;
    tile_t o_data_load;
    tile_t o_att_data;
    logic [1:0]        o_bram_sel_mat;
    logic [LINE_W-1:0] o_bram_sel_line;
    logic [COL_W-1:0]  o_bram_sel_col;

    int    exp_acc[$];
    tile_t ref_o [N_QO_TILES][N_COL];
    tile_t last_k;
    tile_t exp_tile;
    int    got_code;
    int    wr_cnt;
    int    sa_cnt;
    int    vld_cnt;
    bit    acc_prev;
    bit    failed;

    tb_clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(RST_CYCLES)) clk_gen_i (
        .o_clk(I_CLK), .o_rst_n(I_RST_N));

    tile_mem_model #(.SEED(SEED), .MAX_LAT(MAX_LAT)) mem_model_i (
        .I_CLK(I_CLK), .i_rd_ena(o_rd_ena), .i_wr_ena(o_wr_ena),
        .i_sel_mat(o_bram_sel_mat), .i_sel_line(o_bram_sel_line),
        .i_sel_col(o_bram_sel_col), .i_wr_tile(o_att_data),
        .o_rd_vld(i_bram_rd_vld), .o_rd_mat(i_bram_rd_mat), .o_wr_done(i_bram_wr_done));

    sa_model #(.SEED(SEED), .MAX_LAT(MAX_LAT)) sa_model_i (
        .I_CLK(I_CLK), .i_sa_start(o_sa_start), .i_mat_1(o_mat_1), .i_mat_2(o_mat_2),
        .i_data_load(o_data_load), .o_sa_vld(i_sa_vld), .o_sa_result(i_sa_result));

    attn_top attn_top_i (.*);

    ////////////////////////////////////////
    // reference tile math
    ////////////////////////////////////////
    function automatic tile_t tile_mul(tile_t a, tile_t b);
        tile_t          m;
        logic [D_W-1:0] acc;
        for (int r = 0; r < TILE; r++) begin
            for (int c = 0; c < TILE; c++) begin
                acc = '0;
                for (int k = 0; k < TILE; k++) acc = acc + a[r][k] * b[k][c];
                m[r][c] = acc;
            end
        end
        return m;
    endfunction

    function automatic tile_t tile_add(tile_t a, tile_t b);
        tile_t m;
        for (int r = 0; r < TILE; r++) begin
            for (int c = 0; c < TILE; c++) m[r][c] = a[r][c] + b[r][c];
        end
        return m;
    endfunction

    function automatic tile_t tile_trans(tile_t a);
        tile_t m;
        for (int r = 0; r < TILE; r++) begin
            for (int c = 0; c < TILE; c++) m[c][r] = a[r][c];
        end
        return m;
    endfunction

    function automatic tile_t diag_tile();
        tile_t m;
        m = '0;
        for (int i = 0; i < TILE; i++) m[i][i] = SCALE_VAL;
        return m;
    endfunction

    // P = (sum over chunks of Q * K^T) * diag(1/sqrt(d_k))
    function automatic tile_t calc_p(int kv, int qo);
        tile_t s;
        s = '0;
        for (int c = 0; c < N_COL; c++) begin
            s = tile_add(s, tile_mul(mem_model_i.q_mem[qo][c],
                                     tile_trans(mem_model_i.k_mem[kv][c])));
        end
        return tile_mul(s, diag_tile());
    endfunction

    function automatic int acc_code(int wr, int mat, int line, int col);
        return wr * 64 + mat * 16 + line * 4 + col;
    endfunction

    task automatic report_value_error(string name, tile_t got, tile_t exp);
        failed = 1'b1;
        $display("Error: time %0t, %s is %h, expected %h", $time, name, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(string msg);
        failed = 1'b1;
        $display("%s (time %0t)", msg, $time);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // monitor, sampled mid-cycle
    ////////////////////////////////////////
    always @(negedge I_CLK) begin
        if (I_RST_N) begin
            if ((o_rd_ena || o_wr_ena) && !acc_prev) begin
                got_code = acc_code(int'(o_wr_ena), int'(o_bram_sel_mat),
                                    int'(o_bram_sel_line), int'(o_bram_sel_col));
                if (exp_acc.size() == 0) begin
                    report_failure("memory access after the last expected one");
                end
                assert (got_code == exp_acc[0]) else
                    report_failure($sformatf("memory access out of order, code %0d not %0d",
                                             got_code, exp_acc[0]));
                void'(exp_acc.pop_front());
                if (o_rd_ena && int'(o_bram_sel_mat) == CODE_K) begin
                    last_k = mem_model_i.k_mem[o_bram_sel_line][o_bram_sel_col];
                end
                if (o_wr_ena) begin
                    exp_tile = tile_add(ref_o[o_bram_sel_line][o_bram_sel_col],
                        tile_mul(calc_p(wr_cnt / (N_QO_TILES * N_COL), int'(o_bram_sel_line)),
                                 mem_model_i.v_mem[wr_cnt / (N_QO_TILES * N_COL)]
                                                  [o_bram_sel_col]));
                    assert (o_att_data == exp_tile) else
                        report_value_error("o_att_data", o_att_data, exp_tile);
                    ref_o[o_bram_sel_line][o_bram_sel_col] = exp_tile;
                    wr_cnt++;
                end
            end
            acc_prev = o_rd_ena || o_wr_ena;

            if (o_sa_start) begin
                if (sa_cnt % SA_PER < N_COL) begin
                    assert (o_mat_2 == tile_trans(last_k)) else
                        report_value_error("o_mat_2", o_mat_2, tile_trans(last_k));
                end else if (sa_cnt % SA_PER == N_COL) begin
                    assert (o_mat_2 == diag_tile()) else
                        report_value_error("o_mat_2", o_mat_2, diag_tile());
                end
                sa_cnt++;
            end

            if (o_data_vld) begin
                vld_cnt++;
                assert (wr_cnt == N_WRITES) else
                    report_failure("o_data_vld came before all O writes were done");
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    initial begin
        i_attn_start = 1'b0;
        wr_cnt       = 0;
        sa_cnt       = 0;
        vld_cnt      = 0;
        acc_prev     = 1'b0;
        failed       = 1'b0;
        last_k       = '0;
        wait (I_RST_N);
        @(negedge I_CLK);
        assert (!o_rd_ena && !o_wr_ena && !o_sa_start && !o_data_vld) else
            report_failure("control outputs are not low after reset");
        assert (o_mat_1 == '0 && o_mat_2 == '0 && o_data_load == '0) else
            report_failure("SA operands are not zero after reset");

        // kv outer, qo inner, K and Q per chunk, then V, O and write per chunk
        for (int kv = 0; kv < N_KV_TILES; kv++) begin
            for (int qo = 0; qo < N_QO_TILES; qo++) begin
                for (int c = 0; c < N_COL; c++) begin
                    exp_acc.push_back(acc_code(0, CODE_K, kv, c));
                    exp_acc.push_back(acc_code(0, CODE_Q, qo, c));
                end
                for (int c = 0; c < N_COL; c++) begin
                    exp_acc.push_back(acc_code(0, CODE_V, kv, c));
                    exp_acc.push_back(acc_code(0, CODE_O, qo, c));
                    exp_acc.push_back(acc_code(1, CODE_O, qo, c));
                end
            end
        end
        for (int l = 0; l < N_QO_TILES; l++) begin
            for (int c = 0; c < N_COL; c++) ref_o[l][c] = mem_model_i.o_mem[l][c];
        end

        @(posedge I_CLK);
        #1 i_attn_start = 1'b1;
        @(posedge I_CLK);
        #1 i_attn_start = 1'b0;

        wait (vld_cnt > 0);
        repeat (10) @(negedge I_CLK);
        assert (vld_cnt == 1) else report_failure("o_data_vld pulsed more than once");
        assert (exp_acc.size() == 0) else report_failure("some expected accesses never came");
        for (int l = 0; l < N_QO_TILES; l++) begin
            for (int c = 0; c < N_COL; c++) begin
                assert (mem_model_i.o_mem[l][c] == ref_o[l][c]) else
                    report_value_error("o_mem", mem_model_i.o_mem[l][c], ref_o[l][c]);
            end
        end

        if (!failed) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/attn_pkg.sv
hdl/tile_mem_if.sv
hdl/attn_tile_seq.sv
hdl/tile_mem_access.sv
hdl/sa_operand_regs.sv
hdl/o_tile_accum.sv
hdl/attn_top.sv
tb/tb_clk_gen.sv
tb/tb_models.sv
tb/attn_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the attention tile sequencer testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f flist.f \
    --top-module attn_tb \
    -o attn_sim

./obj_dir/attn_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
